//--- video_pkg.sv
// Video pattern shared definitions
`default_nettype none

package video_pkg;

    // ======================================================================
    // widths and pixel words
    // ======================================================================
    localparam int COORD_W = 12;                // position counters and coordinates

    typedef union packed {
        logic [15:0] raw;                       // whole rgb565 word
        struct packed {
            logic [4:0] r;                      // red on top
            logic [5:0] g;
            logic [4:0] b;
        } f;                                    // colour field view
    } pixel565_u;

    typedef logic [23:0] pixel888_t;            // expanded output word

    typedef enum logic [1:0] {BARS, SOLID, RAMP, CHECKER} mode_e;

    // ======================================================================
    // colours
    // ======================================================================
    localparam pixel888_t   BLANK_FILL  = 24'h0F550F;   // shown outside active area
    localparam logic [15:0] SOLID_COLOR = 16'h001F;     // pure blue

    localparam logic [0:7][15:0] BAR_COLORS = '{
        16'hFFFF, 16'hFFE0, 16'h07FF, 16'h07E0,         // white yellow cyan green
        16'hF81F, 16'hF800, 16'h001F, 16'h0000          // magenta red blue black
    };

    // ======================================================================
    // 720p timing defaults
    // ======================================================================
    localparam int DEF_H_TOTAL  = 1650;
    localparam int DEF_H_SYNC   = 40;
    localparam int DEF_H_BPORCH = 220;
    localparam int DEF_H_RES    = 1280;
    localparam int DEF_V_TOTAL  = 750;
    localparam int DEF_V_SYNC   = 5;
    localparam int DEF_V_BPORCH = 20;
    localparam int DEF_V_RES    = 720;

    localparam int PIPE_DEPTH = 2;              // pattern reg plus expand reg

endpackage

`default_nettype wire

//--- pixel_counter.sv
// Pixel position counters
`default_nettype none
`timescale 1ns/100ps

module pixel_counter import video_pkg::*;
#(
    parameter int H_TOTAL = DEF_H_TOTAL,
    parameter int V_TOTAL = DEF_V_TOTAL
)
(
    input  wire                 video_clk,
    input  wire                 reset_n,
    output logic [COORD_W-1:0]  h_count_o,      // pixel within line
    output logic [COORD_W-1:0]  v_count_o,      // line within frame
    output logic                line_end_o,     // last pixel of line
    output logic                frame_end_o     // last pixel of frame
);

    localparam logic [COORD_W-1:0] H_LAST = COORD_W'(H_TOTAL - 1);
    localparam logic [COORD_W-1:0] V_LAST = COORD_W'(V_TOTAL - 1);

    logic line_end;
    logic frame_end;

    assign line_end  = (h_count_o == H_LAST);
    assign frame_end = line_end && (v_count_o == V_LAST);

    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            h_count_o <= '0;
            v_count_o <= '0;
        end
        else
        begin
            if (line_end)
                h_count_o <= '0;                            // wrap line
            else
                h_count_o <= h_count_o + 1'b1;

            if (frame_end)
                v_count_o <= '0;                            // wrap frame
            else if (line_end)
                v_count_o <= v_count_o + 1'b1;              // next line
        end
    end

    assign line_end_o  = line_end;
    assign frame_end_o = frame_end;

endmodule

`default_nettype wire

//--- frame_timing_fsm.sv
// Line and frame phase FSM
`default_nettype none
`timescale 1ns/100ps

module frame_timing_fsm import video_pkg::*;
#(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BPORCH = DEF_H_BPORCH,
    parameter int H_RES    = DEF_H_RES,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BPORCH = DEF_V_BPORCH,
    parameter int V_RES    = DEF_V_RES
)
(
    input  wire                 video_clk,
    input  wire                 reset_n,
    input  wire [COORD_W-1:0]   h_count_i,
    input  wire [COORD_W-1:0]   v_count_i,
    input  wire                 line_end_i,
    input  wire                 frame_end_i,
    input  wire mode_e          mode_i,         // free running level
    output logic                hs_o,
    output logic                vs_o,
    output logic                de_o,
    output logic [COORD_W-1:0]  x_o,            // offset into active area
    output logic [COORD_W-1:0]  y_o,
    output mode_e               mode_o          // held for whole frame
);

    localparam logic [1:0] PH_SYNC   = 2'd0;
    localparam logic [1:0] PH_BPORCH = 2'd1;
    localparam logic [1:0] PH_ACTIVE = 2'd2;
    localparam logic [1:0] PH_FPORCH = 2'd3;

    localparam logic [COORD_W-1:0] H_SYNC_END = COORD_W'(H_SYNC);
    localparam logic [COORD_W-1:0] H_ACT_BEG  = COORD_W'(H_SYNC + H_BPORCH);
    localparam logic [COORD_W-1:0] H_ACT_END  = COORD_W'(H_SYNC + H_BPORCH + H_RES);
    localparam logic [COORD_W-1:0] V_SYNC_END = COORD_W'(V_SYNC);
    localparam logic [COORD_W-1:0] V_ACT_BEG  = COORD_W'(V_SYNC + V_BPORCH);
    localparam logic [COORD_W-1:0] V_ACT_END  = COORD_W'(V_SYNC + V_BPORCH + V_RES);

    logic [1:0] h_state_q;
    logic [1:0] h_state_d;
    logic [1:0] v_state_q;
    logic [1:0] v_state_d;
    logic       line_start_q;                   // count shows h == 0
    logic       frame_start_q;                  // count shows h == 0 and v == 0

    // ======================================================================
    // phase transitions at count boundaries
    // ======================================================================
    always_comb
    begin
        h_state_d = h_state_q;
        if (line_start_q)
            h_state_d = PH_SYNC;                // every line opens with sync
        else
        begin
            case (h_state_q)
                PH_SYNC:   if (h_count_i == H_SYNC_END) h_state_d = PH_BPORCH;
                PH_BPORCH: if (h_count_i == H_ACT_BEG)  h_state_d = PH_ACTIVE;
                PH_ACTIVE: if (h_count_i == H_ACT_END)  h_state_d = PH_FPORCH;
                default:   h_state_d = h_state_q;   // front porch to line start
            endcase
        end

        v_state_d = v_state_q;
        if (frame_start_q)
            v_state_d = PH_SYNC;                // every frame opens with sync
        else if (line_start_q)                  // lines change only at h == 0
        begin
            case (v_state_q)
                PH_SYNC:   if (v_count_i == V_SYNC_END) v_state_d = PH_BPORCH;
                PH_BPORCH: if (v_count_i == V_ACT_BEG)  v_state_d = PH_ACTIVE;
                PH_ACTIVE: if (v_count_i == V_ACT_END)  v_state_d = PH_FPORCH;
                default:   v_state_d = v_state_q;   // front porch to frame start
            endcase
        end
    end

    // ======================================================================
    // state and registered outputs
    // ======================================================================
    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            h_state_q     <= PH_FPORCH;         // enters sync on first count
            v_state_q     <= PH_FPORCH;
            line_start_q  <= 1'b1;              // counter sits at 0,0 out of reset
            frame_start_q <= 1'b1;
            hs_o          <= 1'b0;
            vs_o          <= 1'b0;
            de_o          <= 1'b0;
            x_o           <= '0;
            y_o           <= '0;
            mode_o        <= BARS;
        end
        else
        begin
            h_state_q     <= h_state_d;
            v_state_q     <= v_state_d;
            line_start_q  <= line_end_i;        // next count is line start
            frame_start_q <= frame_end_i;
            hs_o          <= (h_state_d == PH_SYNC);
            vs_o          <= (v_state_d == PH_SYNC);
            de_o          <= (h_state_d == PH_ACTIVE) && (v_state_d == PH_ACTIVE);
            x_o           <= (h_state_d == PH_ACTIVE) ? h_count_i - H_ACT_BEG : '0;
            y_o           <= (v_state_d == PH_ACTIVE) ? v_count_i - V_ACT_BEG : '0;
            if (frame_start_q)
                mode_o <= mode_i;               // sampled once per frame
        end
    end

endmodule

`default_nettype wire

//--- pattern_gen.sv
// RGB565 test pattern generator
`default_nettype none
`timescale 1ns/100ps

module pattern_gen import video_pkg::*;
#(
    parameter int H_RES = DEF_H_RES
)
(
    input  wire                 video_clk,
    input  wire                 reset_n,
    input  wire [COORD_W-1:0]   x_i,
    input  wire [COORD_W-1:0]   y_i,
    input  wire mode_e          mode_i,
    input  wire                 de_i,
    output pixel565_u           pixel_o,
    output logic                valid_o         // de one stage later
);

    localparam int BAR_W = H_RES / 8;           // eight equal bars

    logic [COORD_W-1:0] bar_sel;
    pixel565_u          pix_d;

    assign bar_sel = x_i / COORD_W'(BAR_W);

    always_comb
    begin
        case (mode_i)
            BARS:
                pix_d.raw = BAR_COLORS[bar_sel[2:0]];
            SOLID:
                pix_d.raw = SOLID_COLOR;
            RAMP:
            begin
                pix_d.f.r = x_i[4:0];           // 32 step ramp
                pix_d.f.g = {x_i[4:0], 1'b0};   // g has one extra bit
                pix_d.f.b = x_i[4:0];
            end
            default:                            // checkerboard of 8x8 squares
                pix_d.raw = (x_i[3] ^ y_i[3]) ? BAR_COLORS[0] : BAR_COLORS[7];
        endcase
    end

    // pixel only moves while active
    always_ff @(posedge video_clk)
    begin
        if (de_i)
            pixel_o <= pix_d;
    end

    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
            valid_o <= 1'b0;
        else
            valid_o <= de_i;
    end

endmodule

`default_nettype wire

//--- rgb565_expand.sv
// RGB565 to 24-bit expansion
`default_nettype none
`timescale 1ns/100ps

module rgb565_expand import video_pkg::*;
(
    input  wire                 video_clk,
    input  wire                 reset_n,
    input  wire pixel565_u      pixel_i,
    input  wire                 valid_i,
    output pixel888_t           pixel_o
);

    pixel888_t pix_wide;

    // byte order of the downstream converter
    // blue field on top, red at the bottom, low bits zero
    assign pix_wide = {pixel_i.f.b, 3'b000,     // bits 4:0
                       pixel_i.f.g, 2'b00,      // bits 10:5
                       pixel_i.f.r, 3'b000};    // bits 15:11

    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
            pixel_o <= '0;
        else if (valid_i)
            pixel_o <= pix_wide;
        else
            pixel_o <= BLANK_FILL;              // blanking value
    end

endmodule

`default_nettype wire

//--- sync_delay.sv
// Sync and enable delay line
`default_nettype none
`timescale 1ns/100ps

module sync_delay
#(
    parameter int DEPTH = 2                     // stages of pixel pipeline
)
(
    input  wire     video_clk,
    input  wire     reset_n,
    input  wire     hs_i,
    input  wire     vs_i,
    input  wire     de_i,
    output logic    hs_o,
    output logic    vs_o,
    output logic    de_o
);

    logic [DEPTH-1:0] hs_q;                     // bit 0 newest
    logic [DEPTH-1:0] vs_q;
    logic [DEPTH-1:0] de_q;

    always_ff @(posedge video_clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            hs_q <= '0;
            vs_q <= '0;
            de_q <= '0;
        end
        else
        begin
            hs_q <= DEPTH'({hs_q, hs_i});       // shift in, oldest drops
            vs_q <= DEPTH'({vs_q, vs_i});
            de_q <= DEPTH'({de_q, de_i});
        end
    end

    assign hs_o = hs_q[DEPTH-1];
    assign vs_o = vs_q[DEPTH-1];
    assign de_o = de_q[DEPTH-1];

endmodule

`default_nettype wire

//--- video_pattern_top.sv
// Video test pattern source
`default_nettype none
`timescale 1ns/100ps

module video_pattern_top import video_pkg::*;
#(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BPORCH = DEF_H_BPORCH,
    parameter int H_RES    = DEF_H_RES,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BPORCH = DEF_V_BPORCH,
    parameter int V_RES    = DEF_V_RES
)
(
    input  wire         video_clk,
    input  wire         reset_n,
    input  wire mode_e  mode_i,                 // taken at frame start
    output logic        hs_o,
    output logic        vs_o,
    output logic        de_o,
    output pixel888_t   pixel_o
);

    logic [COORD_W-1:0] h_count;
    logic [COORD_W-1:0] v_count;
    logic               line_end;
    logic               frame_end;
    logic               fsm_hs;
    logic               fsm_vs;
    logic               fsm_de;
    logic [COORD_W-1:0] fsm_x;
    logic [COORD_W-1:0] fsm_y;
    mode_e              fsm_mode;
    pixel565_u          pat_pixel;
    logic               pat_valid;

    // ======================================================================
    // timing
    // ======================================================================
    pixel_counter #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) counter_i (
        .video_clk   (video_clk),
        .reset_n     (reset_n),
        .h_count_o   (h_count),
        .v_count_o   (v_count),
        .line_end_o  (line_end),
        .frame_end_o (frame_end)
    );

    frame_timing_fsm #(
        .H_TOTAL (H_TOTAL), .H_SYNC (H_SYNC), .H_BPORCH (H_BPORCH), .H_RES (H_RES),
        .V_TOTAL (V_TOTAL), .V_SYNC (V_SYNC), .V_BPORCH (V_BPORCH), .V_RES (V_RES)
    ) timing_i (
        .video_clk   (video_clk),
        .reset_n     (reset_n),
        .h_count_i   (h_count),
        .v_count_i   (v_count),
        .line_end_i  (line_end),
        .frame_end_i (frame_end),
        .mode_i      (mode_i),
        .hs_o        (fsm_hs),
        .vs_o        (fsm_vs),
        .de_o        (fsm_de),
        .x_o         (fsm_x),
        .y_o         (fsm_y),
        .mode_o      (fsm_mode)
    );

    // ======================================================================
    // pixel pipeline and matching sync delay
    // ======================================================================
    pattern_gen #(.H_RES(H_RES)) pattern_i (
        .video_clk (video_clk),
        .reset_n   (reset_n),
        .x_i       (fsm_x),
        .y_i       (fsm_y),
        .mode_i    (fsm_mode),
        .de_i      (fsm_de),
        .pixel_o   (pat_pixel),                 // stage 1
        .valid_o   (pat_valid)
    );

    rgb565_expand expand_i (
        .video_clk (video_clk),
        .reset_n   (reset_n),
        .pixel_i   (pat_pixel),
        .valid_i   (pat_valid),
        .pixel_o   (pixel_o)                    // stage 2
    );

    sync_delay #(.DEPTH(PIPE_DEPTH)) delay_i (
        .video_clk (video_clk),
        .reset_n   (reset_n),
        .hs_i      (fsm_hs),
        .vs_i      (fsm_vs),
        .de_i      (fsm_de),
        .hs_o      (hs_o),
        .vs_o      (vs_o),
        .de_o      (de_o)
    );

endmodule

`default_nettype wire

//--- tb_checker.sv
// Video pattern output checker
`default_nettype none
`timescale 1ns/100ps

module tb_checker
#(
    parameter int H_TOTAL  = 48,
    parameter int H_SYNC   = 4,
    parameter int H_BPORCH = 6,
    parameter int H_RES    = 32,
    parameter int V_TOTAL  = 12,
    parameter int V_SYNC   = 2,
    parameter int V_BPORCH = 2,
    parameter int V_RES    = 8
)
(
    input  wire         video_clk,
    input  wire         reset_n,
    input  wire [1:0]   mode_i,                 // mode applied to the DUT
    input  wire         hs_i,
    input  wire         vs_i,
    input  wire         de_i,
    input  wire [23:0]  pixel_i
);

    localparam int FRAME = H_TOTAL * V_TOTAL;
    localparam int LAT   = 3;                   // counter to output pins
    localparam int H_ACT = H_SYNC + H_BPORCH;
    localparam int V_ACT = V_SYNC + V_BPORCH;

    int         edge_cnt;                       // edges since reset release
    int         x_cnt;                          // de cycles in this line
    int         y_cnt;                          // de lines since vs rise
    logic       de_q;
    logic       vs_q;
    logic [1:0] frame_mode [0:63];              // mode latched per frame
    logic [3:0] modes_seen;
    int         frame_count;
    int         err_count;
    int         checks [5];
    int         fails [5];
    string      test_name [5] = '{"reset", "timing", "pixels", "mode_latch", "blank_fill"};

    initial
    begin
        edge_cnt    = 0;
        x_cnt       = 0;
        y_cnt       = 0;
        de_q        = 1'b0;
        vs_q        = 1'b0;
        modes_seen  = '0;
        frame_count = 0;
        err_count   = 0;
        for (int i = 0; i < 5; i++)
        begin
            checks[i] = 0;
            fails[i]  = 0;
        end
    end

    // ======================================================================
    // reference pattern
    // ======================================================================
    function automatic logic [15:0] bar_color(input int idx);
        case (idx)
            0:       bar_color = 16'hFFFF;      // white
            1:       bar_color = 16'hFFE0;      // yellow
            2:       bar_color = 16'h07FF;      // cyan
            3:       bar_color = 16'h07E0;      // green
            4:       bar_color = 16'hF81F;      // magenta
            5:       bar_color = 16'hF800;      // red
            6:       bar_color = 16'h001F;      // blue
            default: bar_color = 16'h0000;      // black
        endcase
    endfunction

    function automatic logic [15:0] pattern565(input logic [1:0] mode, input int x, input int y);
        case (mode)
            2'd0:    pattern565 = bar_color(x / (H_RES / 8));
            2'd1:    pattern565 = 16'h001F;
            2'd2:    pattern565 = {x[4:0], x[4:0], 1'b0, x[4:0]};
            default: pattern565 = (x[3] ^ y[3]) ? 16'hFFFF : 16'h0000;
        endcase
    endfunction

    // b on top, then g, then r, low bits zero
    function automatic logic [23:0] expand(input logic [15:0] p);
        expand = {p[4:0], 3'b000, p[10:5], 2'b00, p[15:11], 3'b000};
    endfunction

    task automatic compare(input int test, input string name, input logic [23:0] got,
                           input logic [23:0] exp);
        checks[test]++;
        if (got !== exp)
        begin
            fails[test]++;
            err_count++;
            $display("FAILED %s at edge %0d: got %h expected %h", name, edge_cnt, got, exp);
        end
    endtask

    // ======================================================================
    // per-cycle comparison
    // ======================================================================
    always @(posedge video_clk)
    begin
        int         k;
        int         h;
        int         v;
        int         f;
        logic [1:0] fm;
        logic [23:0] exp;
        if (!reset_n)
        begin
            edge_cnt = 0;
            compare(0, "hs_o", 24'(hs_i), 24'h0);
            compare(0, "vs_o", 24'(vs_i), 24'h0);
            compare(0, "de_o", 24'(de_i), 24'h0);
            compare(0, "pixel_o", pixel_i, 24'h0);
        end
        else
        begin
            if (edge_cnt % FRAME == 0)
                frame_mode[(edge_cnt / FRAME) % 64] = mode_i;   // counter at 0,0
            if (edge_cnt >= LAT)
            begin
                k  = edge_cnt - LAT;
                h  = k % H_TOTAL;
                v  = (k / H_TOTAL) % V_TOTAL;
                f  = k / FRAME;
                fm = frame_mode[f % 64];
                compare(1, "hs_o", 24'(hs_i), 24'(h < H_SYNC));
                compare(1, "vs_o", 24'(vs_i), 24'(v < V_SYNC));
                compare(1, "de_o", 24'(de_i), 24'((h >= H_ACT) && (h < H_ACT + H_RES) &&
                                                  (v >= V_ACT) && (v < V_ACT + V_RES)));
                if (vs_i && !vs_q)
                begin
                    frame_count++;
                    y_cnt = 0;
                end
                if (de_i)
                begin
                    exp = expand(pattern565(fm, x_cnt, y_cnt));
                    compare(2, "pixel_o", pixel_i, exp);
                    modes_seen[fm] = 1'b1;
                    if (mode_i != fm)           // changed since frame start
                        compare(3, "pixel_o", pixel_i, exp);
                    x_cnt++;
                end
                else
                begin
                    if (de_q)
                        y_cnt++;                // line with de just ended
                    x_cnt = 0;
                    if (k >= FRAME)
                        compare(4, "pixel_o", pixel_i, 24'h0F550F);
                end
                vs_q = vs_i;
                de_q = de_i;
            end
            edge_cnt++;
        end
    end

    // ======================================================================
    // summary
    // ======================================================================
    task automatic report();
        int total;
        total = 0;
        for (int i = 0; i < 5; i++)
        begin
            total += checks[i];
            if (checks[i] == 0)
            begin
                err_count++;
                $display("test %s was never exercised", test_name[i]);
            end
            else
                $display("test %s: %0d checks, %0d failed", test_name[i], checks[i], fails[i]);
        end
        if (modes_seen != 4'hF)
        begin
            err_count++;
            $display("not every pattern mode was shown in a frame (seen %b)", modes_seen);
        end
        $display("checks %0d, errors %0d, frames %0d", total, err_count, frame_count);
    endtask

endmodule

`default_nettype wire

//--- tb_top.sv
// Video pattern source testbench
`default_nettype none
`timescale 1ns/100ps

module tb_top import video_pkg::*;;

    localparam int H_TOTAL  = 48;
    localparam int H_SYNC   = 4;
    localparam int H_BPORCH = 6;
    localparam int H_RES    = 32;
    localparam int V_TOTAL  = 12;
    localparam int V_SYNC   = 2;
    localparam int V_BPORCH = 2;
    localparam int V_RES    = 8;
    localparam int FRAMES   = 10;
    localparam int LIMIT    = FRAMES * H_TOTAL * V_TOTAL + 100;     // 5860 cycles

    logic        video_clk;
    logic        reset_n;
    mode_e       mode_i;
    logic        hs_o;
    logic        vs_o;
    logic        de_o;
    pixel888_t   pixel_o;
    int          seed;
    int          cycle_cnt;
    int          next_change;                   // cycle of next mode step

    always #50 video_clk = ~video_clk;          // 100 ns period

    video_pattern_top #(
        .H_TOTAL (H_TOTAL), .H_SYNC (H_SYNC), .H_BPORCH (H_BPORCH), .H_RES (H_RES),
        .V_TOTAL (V_TOTAL), .V_SYNC (V_SYNC), .V_BPORCH (V_BPORCH), .V_RES (V_RES)
    ) dut_i (
        .video_clk (video_clk),
        .reset_n   (reset_n),
        .mode_i    (mode_i),
        .hs_o      (hs_o),
        .vs_o      (vs_o),
        .de_o      (de_o),
        .pixel_o   (pixel_o)
    );

    tb_checker #(
        .H_TOTAL (H_TOTAL), .H_SYNC (H_SYNC), .H_BPORCH (H_BPORCH), .H_RES (H_RES),
        .V_TOTAL (V_TOTAL), .V_SYNC (V_SYNC), .V_BPORCH (V_BPORCH), .V_RES (V_RES)
    ) chk_i (
        .video_clk (video_clk),
        .reset_n   (reset_n),
        .mode_i    (mode_i),
        .hs_i      (hs_o),
        .vs_i      (vs_o),
        .de_i      (de_o),
        .pixel_i   (pixel_o)
    );

    // mode steps through all four values, gaps longer than a frame
    always @(posedge video_clk)
    begin
        if (reset_n)
        begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt == next_change)
            begin
                mode_i      <= mode_e'(mode_i + 2'd1);
                next_change <= cycle_cnt + 600 + int'($unsigned($random(seed)) % 401);
            end
        end
    end

    initial
    begin
        video_clk   = 1'b0;
        reset_n     = 1'b0;
        mode_i      = BARS;
        seed        = 32'ha139_554c;
        cycle_cnt   = 0;
        next_change = 300;
        repeat (3) @(posedge video_clk);
        reset_n <= 1'b1;
        while (chk_i.frame_count < FRAMES && cycle_cnt < LIMIT)
            @(posedge video_clk);
        chk_i.report();
        if (cycle_cnt >= LIMIT || chk_i.err_count != 0)
        begin
            if (cycle_cnt >= LIMIT)
                $display("timeout after %0d cycles, frames did not complete", cycle_cnt);
            $display("Simulation failed");
        end
        else
            $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
video_pkg.sv
pixel_counter.sv
frame_timing_fsm.sv
pattern_gen.sv
rgb565_expand.sv
sync_delay.sv
video_pattern_top.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_top -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
